/* hdl/rotator_pkg.sv */
// weight rotator package with the word width, dimension limits, user flags and beat decoding
package rotator_pkg;

  // ==========================================================================
  // widths and dimension limits
  // ==========================================================================

  localparam int DATA_W = 32;

  localparam int KH_MAX     = 3;
  localparam int KW_MAX     = 3;
  localparam int CIN_MAX    = 8;
  localparam int COLS_MAX   = 8;
  localparam int BLOCKS_MAX = 4;

  // each field holds a minus-one value, so max-1 must fit
  localparam int BITS_KH     = $clog2(KH_MAX);
  localparam int BITS_KW     = $clog2(KW_MAX);
  localparam int BITS_CIN    = $clog2(CIN_MAX);
  localparam int BITS_COLS   = $clog2(COLS_MAX);
  localparam int BITS_BLOCKS = $clog2(BLOCKS_MAX);

  localparam int HDR_W = BITS_BLOCKS + BITS_COLS + BITS_CIN + BITS_KH + BITS_KW;

  // master tuser layout, five flags with the kernel width field on top
  localparam int TU_IS_TOP       = 0;
  localparam int TU_IS_BOTTOM    = 1;
  localparam int TU_IS_CIN_LAST  = 2;
  localparam int TU_IS_1X1       = 3;
  localparam int TU_IS_COLS_1_K2 = 4;
  localparam int TU_KW_1         = 5;
  localparam int TUSER_W         = TU_KW_1 + BITS_KW;

  // ==========================================================================
  // header and beat types
  // ==========================================================================

  typedef struct packed {
    logic [BITS_BLOCKS-1:0] blocks_1;
    logic [BITS_COLS-1:0]   cols_1;
    logic [BITS_CIN-1:0]    cin_1;
    logic [BITS_KH-1:0]     kh_1;
    logic [BITS_KW-1:0]     kw_1;
  } hdr_t;

  // the first beat of a frame is a header, every other one is a weight word
  typedef union packed {
    logic [DATA_W-1:0] word;
    struct packed {
      logic [DATA_W-HDR_W-1:0] pad;
      hdr_t                    hdr;
    } head;
  } beat_u;

endpackage

/* hdl/bank_wr_if.sv */
// write side of the ping-pong weight buffers, between the input FSM and the bank
`timescale 1ns/1ps

interface bank_wr_if;

  // header of the frame about to be written, loaded with hdr_load
  logic                             hdr_load;
  rotator_pkg::hdr_t                hdr;

  // one weight word per wr_en, stored at the next sequential address
  logic                             wr_en;
  logic [rotator_pkg::DATA_W-1:0]   wr_data;

  // marks the buffer full and moves to the other one
  logic                             commit;

  // buffer under the write pointer is empty
  logic                             free;

  modport wr (
    output hdr_load, hdr, wr_en, wr_data, commit,
    input  free
  );

  modport bank (
    input  hdr_load, hdr, wr_en, wr_data, commit,
    output free
  );

endinterface

/* hdl/bank_rd_if.sv */
// read side of the ping-pong weight buffers, between the bank and the output FSM
`timescale 1ns/1ps

interface bank_rd_if #(
  parameter int DEPTH = rotator_pkg::KH_MAX * rotator_pkg::CIN_MAX
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // address into the buffer under the read pointer
  logic [ADDR_W-1:0]              rd_addr;

  // empties the current buffer and moves to the other one
  logic                           buf_release;

  // buffer under the read pointer holds a complete frame
  logic                           avail;
  rotator_pkg::hdr_t              hdr;
  logic [rotator_pkg::DATA_W-1:0] rd_data;

  modport rd (
    output rd_addr, buf_release,
    input  avail, hdr, rd_data
  );

  modport bank (
    input  rd_addr, buf_release,
    output avail, hdr, rd_data
  );

endinterface

/* hdl/weight_bank.sv */
// ping-pong weight buffers with stored headers, full flags and bank pointers
`timescale 1ns/1ps

module weight_bank #(
  parameter int DEPTH = rotator_pkg::KH_MAX * rotator_pkg::CIN_MAX
) (
  input  logic    aclk,
  input  logic    i_rst_n,
  bank_wr_if.bank wr_bus,
  bank_rd_if.bank rd_bus
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [rotator_pkg::DATA_W-1:0] mem [2][DEPTH];
  rotator_pkg::hdr_t              hdr_q [2];
  logic [1:0]                     full;
  logic [ADDR_W-1:0]              wr_addr;
  logic                           wr_ptr;
  logic                           rd_ptr;

  // ==========================================================================
  // storage
  // ==========================================================================

  always_ff @(posedge aclk) begin
    if (wr_bus.wr_en) begin
      mem[wr_ptr][wr_addr] <= wr_bus.wr_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_bus.hdr_load) begin
      hdr_q[wr_ptr] <= wr_bus.hdr;
    end
  end

  // ==========================================================================
  // pointers and full flags
  // ==========================================================================

  // a new header restarts the address, each write moves it by one
  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_addr <= '0;
    end else if (wr_bus.hdr_load) begin
      wr_addr <= '0;
    end else if (wr_bus.wr_en) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  // commit and release never touch the same flag, since commit needs an
  // empty buffer and release a full one
  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      full   <= '0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      if (wr_bus.commit) begin
        full[wr_ptr] <= 1'b1;
        wr_ptr       <= ~wr_ptr;
      end
      if (rd_bus.buf_release) begin
        full[rd_ptr] <= 1'b0;
        rd_ptr       <= ~rd_ptr;
      end
    end
  end

  assign wr_bus.free = ~full[wr_ptr];

  // the read side always sees the buffer under the read pointer
  assign rd_bus.avail   = full[rd_ptr];
  assign rd_bus.hdr     = hdr_q[rd_ptr];
  assign rd_bus.rd_data = mem[rd_ptr][rd_bus.rd_addr];

  // ==========================================================================
  // checks
  // ==========================================================================

  // the writer must only fill a buffer the reader has already drained
  a_no_write_full : assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    (wr_bus.wr_en || wr_bus.hdr_load) |-> !full[wr_ptr]
  ) else $error("weight_bank: write into a full buffer");

  a_no_release_empty : assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    rd_bus.buf_release |-> full[rd_ptr]
  ) else $error("weight_bank: release of an empty buffer");

endmodule

/* hdl/write_ctrl.sv */
// input stream FSM that parses the frame header and writes the weight beats
`timescale 1ns/1ps

module write_ctrl #(
  parameter int DEPTH = rotator_pkg::KH_MAX * rotator_pkg::CIN_MAX
) (
  input  logic                           aclk,
  input  logic                           i_rst_n,
  input  logic                           i_s_tvalid,
  input  logic [rotator_pkg::DATA_W-1:0] i_s_tdata,
  input  logic                           i_s_tlast,
  output logic                           o_s_tready,
  bank_wr_if.wr                          wr_bus
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef enum logic {
    S_HDR,
    S_WGT
  } state_t;

  state_t             state;
  rotator_pkg::beat_u beat;
  logic               s_hs;
  logic               last_beat;
  logic [ADDR_W-1:0]  beats_left;
  logic [ADDR_W-1:0]  beats_load;

  assign beat.word = i_s_tdata;

  // a header is only taken when the next buffer is empty
  assign o_s_tready = (state == S_HDR) ? wr_bus.free : 1'b1;
  assign s_hs       = i_s_tvalid && o_s_tready;
  assign last_beat  = (beats_left == '0);

  // frame holds (kh_1+1)*(cin_1+1) weight words, the counter runs down to zero
  assign beats_load = ADDR_W'((int'(beat.head.hdr.kh_1) + 1) *
                              (int'(beat.head.hdr.cin_1) + 1) - 1);

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= S_HDR;
      beats_left <= '0;
    end else begin
      case (state)
        S_HDR: begin
          if (s_hs) begin
            state      <= S_WGT;
            beats_left <= beats_load;
          end
        end
        S_WGT: begin
          if (s_hs) begin
            if (last_beat) begin
              state <= S_HDR;
            end else begin
              beats_left <= beats_left - 1'b1;
            end
          end
        end
        default: state <= S_HDR;
      endcase
    end
  end

  assign wr_bus.hdr_load = (state == S_HDR) && s_hs;
  assign wr_bus.hdr      = beat.head.hdr;
  assign wr_bus.wr_en    = (state == S_WGT) && s_hs;
  assign wr_bus.wr_data  = beat.word;
  assign wr_bus.commit   = wr_bus.wr_en && last_beat;

  // tlast from the source has to agree with the count from the header
  a_tlast_match : assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    s_hs |-> (i_s_tlast == ((state == S_WGT) && last_beat))
  ) else $error("write_ctrl: input tlast disagrees with header count");

  a_frame_fits : assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    wr_bus.hdr_load |->
      (int'(beat.head.hdr.kh_1) + 1) * (int'(beat.head.hdr.cin_1) + 1) <= DEPTH
  ) else $error("write_ctrl: frame does not fit the buffer depth");

endmodule

/* hdl/read_ctrl.sv */
// output stream FSM that replays the stored frame with nested counters and user flags
`timescale 1ns/1ps

module read_ctrl #(
  parameter int DEPTH = rotator_pkg::KH_MAX * rotator_pkg::CIN_MAX
) (
  input  logic                            aclk,
  input  logic                            i_rst_n,
  bank_rd_if.rd                           rd_bus,
  input  logic                            i_m_tready,
  output logic                            o_m_tvalid,
  output logic [rotator_pkg::DATA_W-1:0]  o_m_tdata,
  output logic                            o_m_tlast,
  output logic [rotator_pkg::TUSER_W-1:0] o_m_tuser
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // all four counters share the widest field width
  localparam int W_A   = (rotator_pkg::BITS_KH > rotator_pkg::BITS_CIN) ?
                         rotator_pkg::BITS_KH : rotator_pkg::BITS_CIN;
  localparam int W_B   = (rotator_pkg::BITS_COLS > rotator_pkg::BITS_BLOCKS) ?
                         rotator_pkg::BITS_COLS : rotator_pkg::BITS_BLOCKS;
  localparam int CNT_W = (W_A > W_B) ? W_A : W_B;

  // counter levels, innermost first
  localparam int L_KH     = 0;
  localparam int L_CIN    = 1;
  localparam int L_COLS   = 2;
  localparam int L_BLOCKS = 3;

  typedef enum logic {
    R_IDLE,
    R_STREAM
  } state_t;

  state_t           state;
  logic             start;
  logic             m_hs;
  logic [CNT_W-1:0] cnt     [4];
  logic [CNT_W-1:0] top_val [4];
  logic [3:0]       last;
  logic [3:0]       step;
  logic [CNT_W-1:0] kh_pos;
  logic [CNT_W-1:0] cin_pos;

  assign top_val[L_KH]     = CNT_W'(rd_bus.hdr.kh_1);
  assign top_val[L_CIN]    = CNT_W'(rd_bus.hdr.cin_1);
  assign top_val[L_COLS]   = CNT_W'(rd_bus.hdr.cols_1);
  assign top_val[L_BLOCKS] = CNT_W'(rd_bus.hdr.blocks_1);

  assign o_m_tvalid = (state == R_STREAM);
  assign m_hs       = o_m_tvalid && i_m_tready;
  assign start      = (state == R_IDLE) && rd_bus.avail;

  // ==========================================================================
  // FSM and counters
  // ==========================================================================

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= R_IDLE;
    end else if (start) begin
      state <= R_STREAM;
    end else if (m_hs && o_m_tlast) begin
      state <= R_IDLE;
    end
  end

  // an outer level moves only when every inner level wraps
  assign step[L_KH]     = m_hs;
  assign step[L_CIN]    = m_hs && last[L_KH];
  assign step[L_COLS]   = m_hs && last[L_KH] && last[L_CIN];
  assign step[L_BLOCKS] = m_hs && last[L_KH] && last[L_CIN] && last[L_COLS];

  // down-counters from the header value to zero, with the last flag registered
  // alongside so the flags come straight out of flops
  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 4; i++) begin
        cnt[i] <= '0;
      end
      last <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (start || (step[i] && last[i])) begin
          cnt[i]  <= top_val[i];
          last[i] <= (top_val[i] == '0);
        end else if (step[i]) begin
          cnt[i]  <= cnt[i] - 1'b1;
          last[i] <= (cnt[i] == CNT_W'(1));
        end
      end
    end
  end

  // ==========================================================================
  // address, data and flags
  // ==========================================================================

  // frame is stored cin-major with kh running fastest
  assign kh_pos         = top_val[L_KH] - cnt[L_KH];
  assign cin_pos        = top_val[L_CIN] - cnt[L_CIN];
  assign rd_bus.rd_addr = ADDR_W'(int'(cin_pos) * (int'(top_val[L_KH]) + 1) + int'(kh_pos));

  assign o_m_tdata          = rd_bus.rd_data;
  assign o_m_tlast          = &last;
  assign rd_bus.buf_release = m_hs && o_m_tlast;

  always_comb begin
    o_m_tuser                               = '0;
    o_m_tuser[rotator_pkg::TU_IS_TOP]       = (cnt[L_BLOCKS] == top_val[L_BLOCKS]);
    o_m_tuser[rotator_pkg::TU_IS_BOTTOM]    = last[L_BLOCKS];
    o_m_tuser[rotator_pkg::TU_IS_CIN_LAST]  = last[L_KH] && last[L_CIN];
    o_m_tuser[rotator_pkg::TU_IS_1X1]       = (rd_bus.hdr.kw_1 == '0);
    // remaining cols equal to kw_1/2 marks column cols-1-k/2
    o_m_tuser[rotator_pkg::TU_IS_COLS_1_K2] = (cnt[L_COLS] == CNT_W'(rd_bus.hdr.kw_1 >> 1));
    o_m_tuser[rotator_pkg::TU_KW_1 +: rotator_pkg::BITS_KW] = rd_bus.hdr.kw_1;
  end

  a_hold_stable : assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    (o_m_tvalid && !i_m_tready) |=>
      (o_m_tvalid && $stable(o_m_tdata) && $stable(o_m_tuser) && $stable(o_m_tlast))
  ) else $error("read_ctrl: output beat changed while stalled");

endmodule

/* hdl/axis_weight_rotator.sv */
// weight rotator top level with input parsing, ping-pong buffers and rotated output stream
`timescale 1ns/1ps

module axis_weight_rotator #(
  parameter int DEPTH = rotator_pkg::KH_MAX * rotator_pkg::CIN_MAX
) (
  input  logic                            aclk,
  input  logic                            i_rst_n,

  // slave stream with the header beat followed by the weight words
  input  logic                            i_s_tvalid,
  output logic                            o_s_tready,
  input  logic [rotator_pkg::DATA_W-1:0]  i_s_tdata,
  input  logic                            i_s_tlast,

  // master stream with the rotated weights
  output logic                            o_m_tvalid,
  input  logic                            i_m_tready,
  output logic [rotator_pkg::DATA_W-1:0]  o_m_tdata,
  output logic                            o_m_tlast,
  output logic [rotator_pkg::TUSER_W-1:0] o_m_tuser
);

  bank_wr_if u_wr_if ();

  bank_rd_if #(
    .DEPTH (DEPTH)
  ) u_rd_if ();

  write_ctrl #(
    .DEPTH      (DEPTH)
  ) u_write_ctrl (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .i_s_tvalid (i_s_tvalid),
    .i_s_tdata  (i_s_tdata),
    .i_s_tlast  (i_s_tlast),
    .o_s_tready (o_s_tready),
    .wr_bus     (u_wr_if.wr)
  );

  weight_bank #(
    .DEPTH   (DEPTH)
  ) u_weight_bank (
    .aclk    (aclk),
    .i_rst_n (i_rst_n),
    .wr_bus  (u_wr_if.bank),
    .rd_bus  (u_rd_if.bank)
  );

  read_ctrl #(
    .DEPTH      (DEPTH)
  ) u_read_ctrl (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .rd_bus     (u_rd_if.rd),
    .i_m_tready (i_m_tready),
    .o_m_tvalid (o_m_tvalid),
    .o_m_tdata  (o_m_tdata),
    .o_m_tlast  (o_m_tlast),
    .o_m_tuser  (o_m_tuser)
  );

endmodule

/* tests/tb_model.svh */
// reference model and frame drivers for the weight rotator testbench

  // ==========================================================================
  // reference model
  // ==========================================================================

  // builds a header from the real dimensions, each field stores the value minus one
  function automatic rotator_pkg::hdr_t make_hdr(input int blocks, input int cols,
                                                 input int cin, input int kh, input int kw);
    rotator_pkg::hdr_t h;
    h.blocks_1 = B_BLK'(blocks - 1);
    h.cols_1   = B_COLS'(cols - 1);
    h.cin_1    = B_CIN'(cin - 1);
    h.kh_1     = B_KH'(kh - 1);
    h.kw_1     = B_KW'(kw - 1);
    return h;
  endfunction

  // expected beat n of a frame, packed as data, last and user from the top down
  function automatic logic [EXP_W-1:0] expected_beat(input rotator_pkg::hdr_t h,
                                                     input logic [DATA_W-1:0] w [DEPTH],
                                                     input int n);
    int                 kh_n;
    int                 cin_n;
    int                 cols_n;
    int                 kh_p;
    int                 cin_p;
    int                 col_p;
    int                 blk_p;
    int                 rest;
    logic [DATA_W-1:0]  data;
    logic               last;
    logic [TUSER_W-1:0] user;
    kh_n   = int'(h.kh_1) + 1;
    cin_n  = int'(h.cin_1) + 1;
    cols_n = int'(h.cols_1) + 1;
    // kh runs fastest, then cin, then cols, blocks outermost
    kh_p  = n % kh_n;
    rest  = n / kh_n;
    cin_p = rest % cin_n;
    rest  = rest / cin_n;
    col_p = rest % cols_n;
    blk_p = rest / cols_n;
    data = w[cin_p * kh_n + kh_p];
    last = (kh_p == int'(h.kh_1)) && (cin_p == int'(h.cin_1)) &&
           (col_p == int'(h.cols_1)) && (blk_p == int'(h.blocks_1));
    user = '0;
    user[rotator_pkg::TU_IS_TOP]       = (blk_p == 0);
    user[rotator_pkg::TU_IS_BOTTOM]    = (blk_p == int'(h.blocks_1));
    user[rotator_pkg::TU_IS_CIN_LAST]  = (kh_p == int'(h.kh_1)) && (cin_p == int'(h.cin_1));
    user[rotator_pkg::TU_IS_1X1]       = (h.kw_1 == '0);
    // remaining columns against half the kernel width
    user[rotator_pkg::TU_IS_COLS_1_K2] = ((int'(h.cols_1) - col_p) == (int'(h.kw_1) / 2));
    user[rotator_pkg::TU_KW_1 +: rotator_pkg::BITS_KW] = h.kw_1;
    return {data, last, user};
  endfunction

  // ==========================================================================
  // slave stream drivers
  // ==========================================================================

  task automatic fill_weights();
    for (int i = 0; i < DEPTH; i++) begin
      wts[i] = DATA_W'($urandom());
    end
  endtask

  // entered and left 1 ns after a rising edge
  task automatic send_beat(input logic [DATA_W-1:0] data, input logic last);
    int waited;
    if (s_gaps) begin
      repeat ($urandom_range(0, 2)) begin
        @(posedge aclk);
        #1;
      end
    end
    i_s_tvalid = 1'b1;
    i_s_tdata  = data;
    i_s_tlast  = last;
    waited     = 0;
    @(posedge aclk);
    while (!o_s_tready) begin
      waited++;
      assert (waited < WAIT_LIMIT)
        else stop_with_error("input beat was never accepted by the DUT");
      @(posedge aclk);
    end
    #1;
    i_s_tvalid = 1'b0;
    i_s_tlast  = 1'b0;
  endtask

  // queues the whole expected output of the frame, then sends header and weights
  task automatic send_frame(input string name, input rotator_pkg::hdr_t h);
    rotator_pkg::beat_u head;
    int                 n_wgt;
    int                 n_out;
    n_wgt = (int'(h.kh_1) + 1) * (int'(h.cin_1) + 1);
    n_out = n_wgt * (int'(h.cols_1) + 1) * (int'(h.blocks_1) + 1);
    for (int n = 0; n < n_out; n++) begin
      exp_q.push_back(expected_beat(h, wts, n));
      name_q.push_back(name);
    end
    head.word     = '0;
    head.head.hdr = h;
    send_beat(head.word, 1'b0);
    for (int i = 0; i < n_wgt; i++) begin
      send_beat(wts[i], (i == n_wgt - 1));
    end
  endtask

/* tests/tb_weight_rotator.sv */
// testbench for the weight rotator that checks every output beat against a reference model
`timescale 1ns/1ps

module tb_weight_rotator;

  localparam int DATA_W     = rotator_pkg::DATA_W;
  localparam int TUSER_W    = rotator_pkg::TUSER_W;
  localparam int EXP_W      = DATA_W + 1 + TUSER_W;
  localparam int DEPTH      = rotator_pkg::KH_MAX * rotator_pkg::CIN_MAX;
  localparam int WAIT_LIMIT = 200;

  localparam int B_BLK  = rotator_pkg::BITS_BLOCKS;
  localparam int B_COLS = rotator_pkg::BITS_COLS;
  localparam int B_CIN  = rotator_pkg::BITS_CIN;
  localparam int B_KH   = rotator_pkg::BITS_KH;
  localparam int B_KW   = rotator_pkg::BITS_KW;

  logic               aclk;
  logic               i_rst_n;
  logic               i_s_tvalid;
  logic               o_s_tready;
  logic [DATA_W-1:0]  i_s_tdata;
  logic               i_s_tlast;
  logic               o_m_tvalid;
  logic               i_m_tready;
  logic [DATA_W-1:0]  o_m_tdata;
  logic               o_m_tlast;
  logic [TUSER_W-1:0] o_m_tuser;

  // expected beats in output order and the test each one belongs to
  logic [EXP_W-1:0]   exp_q [$];
  string              name_q [$];
  logic [DATA_W-1:0]  wts [DEPTH];
  logic               s_gaps;
  logic               m_stalls;
  int                 beat_no = 0;
  int unsigned        seed_val;

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_model.svh"

  axis_weight_rotator #(
    .DEPTH      (DEPTH)
  ) u_dut (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .i_s_tvalid (i_s_tvalid),
    .o_s_tready (o_s_tready),
    .i_s_tdata  (i_s_tdata),
    .i_s_tlast  (i_s_tlast),
    .o_m_tvalid (o_m_tvalid),
    .i_m_tready (i_m_tready),
    .o_m_tdata  (o_m_tdata),
    .o_m_tlast  (o_m_tlast),
    .o_m_tuser  (o_m_tuser)
  );

  initial aclk = 1'b0;
  always #2 aclk = ~aclk;

  // master ready goes low at random a quarter of the time while stalls are on
  always @(posedge aclk) begin
    #1;
    if (m_stalls) begin
      i_m_tready = ($urandom_range(0, 3) != 0);
    end else begin
      i_m_tready = 1'b1;
    end
  end

  // ==========================================================================
  // compare process
  // ==========================================================================

  always @(posedge aclk) begin : compare_beats
    logic [EXP_W-1:0] want;
    string            name;
    if (i_rst_n && o_m_tvalid && i_m_tready) begin
      assert (exp_q.size() != 0)
        else stop_with_error("output beat arrived while no beat was expected");
      want = exp_q.pop_front();
      name = name_q.pop_front();
      assert (o_m_tdata == want[EXP_W-1 -: DATA_W])
        else stop_with_error($sformatf("Mismatch %s beat %0d tdata: expected %h, actual %h",
                                       name, beat_no, want[EXP_W-1 -: DATA_W], o_m_tdata));
      assert (o_m_tlast == want[TUSER_W])
        else stop_with_error($sformatf("Mismatch %s beat %0d tlast: expected %b, actual %b",
                                       name, beat_no, want[TUSER_W], o_m_tlast));
      assert (o_m_tuser == want[TUSER_W-1:0])
        else stop_with_error($sformatf("Mismatch %s beat %0d tuser: expected %h, actual %h",
                                       name, beat_no, want[TUSER_W-1:0], o_m_tuser));
      beat_no++;
    end
  end

  // once every expected beat is out the reader has to be idle again
  task automatic wait_drain(input int limit);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      assert (waited < limit)
        else stop_with_error($sformatf("output stream stopped with %0d beats still missing",
                                       exp_q.size()));
      @(posedge aclk);
      #1;
      waited++;
    end
    assert (!o_m_tvalid)
      else stop_with_error("output stream kept running after the last expected beat");
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin : test_sequence
    rotator_pkg::hdr_t h_main;
    seed_val   = $urandom(32'hc2f4);
    i_rst_n    = 1'b0;
    i_s_tvalid = 1'b0;
    i_s_tdata  = '0;
    i_s_tlast  = 1'b0;
    i_m_tready = 1'b1;
    s_gaps     = 1'b0;
    m_stalls   = 1'b0;
    repeat (16) @(posedge aclk);
    #1;
    i_rst_n = 1'b1;
    @(posedge aclk);
    #1;

    // idle state right after reset
    assert (!o_m_tvalid) else stop_with_error("o_m_tvalid is high after reset with no input");
    assert (o_s_tready) else stop_with_error("o_s_tready is low after reset with no input");

    // one frame with blocks 2, cols 3, cin 2, kh 3 and kw 3 gives 36 beats
    h_main = make_hdr(2, 3, 2, 3, 3);
    fill_weights();
    send_frame("single_frame", h_main);
    wait_drain(2000);

    // same frame and weights again with stalls on both streams
    s_gaps   = 1'b1;
    m_stalls = 1'b1;
    send_frame("stalled_frame", h_main);
    wait_drain(4000);
    s_gaps   = 1'b0;
    m_stalls = 1'b0;

    // three frames back to back so one buffer fills while the other streams
    fill_weights();
    send_frame("burst_a", make_hdr(1, 4, 3, 2, 1));
    fill_weights();
    send_frame("burst_b", make_hdr(4, 8, 8, 3, 3));
    fill_weights();
    send_frame("burst_c", make_hdr(2, 2, 5, 1, 2));
    wait_drain(8000);

    // the smallest frame gives a single beat with every edge flag set
    fill_weights();
    send_frame("minimal_frame", make_hdr(1, 1, 1, 1, 1));
    wait_drain(2000);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* all.f */
+incdir+tests
hdl/rotator_pkg.sv
hdl/bank_wr_if.sv
hdl/bank_rd_if.sv
hdl/weight_bank.sv
hdl/write_ctrl.sv
hdl/read_ctrl.sv
hdl/axis_weight_rotator.sv
tests/tb_weight_rotator.sv

/* Makefile */
# Verilator build and run of the weight rotator testbench

VERILATOR ?= verilator
TOP       ?= tb_weight_rotator
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "testbench reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG) || \
		{ echo "run ended without a result, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
